// ==== hdl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	//////////////////////////////////////////////////////////////////////
	// 8b/10b control symbols
	//////////////////////////////////////////////////////////////////////

	// comma, starts every ordered set
	localparam logic [7:0] SYM_COM = 8'hBC;

	// other framing K codes
	localparam logic [7:0] SYM_SKP = 8'h3C;
	localparam logic [7:0] SYM_SDP = 8'h5C;
	localparam logic [7:0] SYM_SHP = 8'hFB;
	// end of packet framing, closes DPH and DPP headers
	localparam logic [7:0] SYM_END = 8'hF7;

	// training set identifiers, sent as data bytes
	localparam logic [7:0] SYM_TS1_ID = 8'h4A;
	localparam logic [7:0] SYM_TS2_ID = 8'h45;

	//////////////////////////////////////////////////////////////////////
	// receive words
	//////////////////////////////////////////////////////////////////////

	// one 32 bit PIPE word with its K flags
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  datak;
	} pipe_word_t;

	// aligned word as seen by the link layer
	typedef struct packed {
		pipe_word_t word;
		logic       active;
	} link_word_t;

	//////////////////////////////////////////////////////////////////////
	// PHY control
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		POWER_P0 = 2'd0,
		POWER_P1 = 2'd1,
		POWER_P2 = 2'd2,
		POWER_P3 = 2'd3
	} power_state_t;

	// RxStatus of one lane
	typedef logic [2:0] lane_status_t;

	// receiver present, as reported during detection
	localparam lane_status_t RXSTAT_DETECTED = 3'b011;

	// cycles between a detect request and the PHY strobe
	localparam int DEFAULT_RXDET_DELAY = 31;
	// about 8 ms at 125 MHz once the top bit sets
	localparam int DEFAULT_RXDET_TIMEOUT_BITS = 21;

endpackage

`default_nettype wire

// ==== hdl/rx_word_align.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_word_align
	import pipe_pkg::*;
(
	input wire local_clk,
	input wire reset_n,
	input wire pipe_word_t phy_rx,
	input wire [1:0] phy_rx_valid,
	output link_word_t link_in
);

	// swapped input word
	link_word_t rx_q;
	// carried bytes or the whole previous word when aligned
	link_word_t a_q;
	// assembled output word
	link_word_t b_q;
	// number of bytes carried from one word into the next
	logic [1:0] align_q;

	pipe_word_t rx_swap;
	logic [3:0] frame_k;
	logic [3:0] end_k;
	logic frame_found;
	logic [1:0] align_next;
	logic [1:0] carry_align;
	logic [1:0] carry_shift;
	logic group_whole;
	logic [31:0] head_mask;
	logic [3:0] headk_mask;
	pipe_word_t spliced;
	pipe_word_t carried;

	function automatic logic is_frame(input logic [7:0] sym, input logic k);
		return k && (sym == SYM_COM || sym == SYM_SKP || sym == SYM_SDP ||
			sym == SYM_SHP || sym == SYM_END);
	endfunction

	function automatic logic is_run_end(input logic [7:0] sym, input logic k);
		return k && (sym == SYM_COM || sym == SYM_END);
	endfunction

	// first byte on the wire goes to the top
	always_comb begin
		rx_swap.data = {<<8{phy_rx.data}};
		rx_swap.datak = {<<{phy_rx.datak}};
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			frame_k[i] = is_frame(rx_q.word.data[8*i +: 8], rx_q.word.datak[i]);
			end_k[i] = is_run_end(rx_q.word.data[8*i +: 8], rx_q.word.datak[i]);
		end
	end

	// length of the framing run that ends in the last byte
	always_comb begin
		frame_found = frame_k[0];
		if (&frame_k && end_k[0])
			align_next = 2'd0;
		else if (&frame_k[2:0])
			align_next = 2'd3;
		else if (&frame_k[1:0])
			align_next = 2'd2;
		else
			align_next = 2'd1;
	end

	assign carry_align = frame_found ? align_next : align_q;
	assign carry_shift = 2'd0 - carry_align;

	// bytes before a new cut only count when they fill a word
	assign group_whole = !frame_found || align_q == 2'd0 ||
		(align_next != 2'd0 && align_next <= align_q);

	assign head_mask = 32'hffff_ffff >> {align_q, 3'b000};
	assign headk_mask = 4'hf >> align_q;

	// carried bytes on top, head of the new word below
	always_comb begin
		spliced.data = (a_q.word.data & ~head_mask) | (rx_q.word.data >> {align_q, 3'b000});
		spliced.datak = (a_q.word.datak & ~headk_mask) | (rx_q.word.datak >> align_q);
	end

	// tail of the new word moved up for the next splice
	always_comb begin
		carried.data = rx_q.word.data << {carry_shift, 3'b000};
		carried.datak = rx_q.word.datak << carry_shift;
	end

	//////////////////////////////////////////////////////////////////////
	// re-cutting pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge local_clk or negedge reset_n) begin
		if (!reset_n) begin
			rx_q <= '0;
			a_q <= '0;
			b_q <= '0;
			align_q <= 2'd0;
		end else begin
			rx_q.word <= rx_swap;
			rx_q.active <= |phy_rx_valid;
			b_q.active <= 1'b0;
			if (rx_q.active) begin
				b_q.word <= (align_q == 2'd0) ? a_q.word : spliced;
				b_q.active <= a_q.active && group_whole;
				a_q.word <= carried;
				a_q.active <= 1'b1;
				align_q <= carry_align;
			end else if (align_q == 2'd0 && a_q.active) begin
				// a whole word needs no partner and moves on
				b_q.word <= a_q.word;
				b_q.active <= 1'b1;
				a_q.active <= 1'b0;
			end
		end
	end

	assign link_in = b_q;

endmodule

`default_nettype wire

// ==== hdl/ts_detect.sv ====
`timescale 1ns/1ns
`default_nettype none

module ts_detect
	import pipe_pkg::*;
(
	input wire local_clk,
	input wire reset_n,
	input wire link_word_t link_in,
	input wire power_state_t power_state,
	output logic ltssm_train_ts1,
	output logic ltssm_train_ts2
);

	typedef enum logic [1:0] {
		TS_IDLE,
		TS_WORD1,
		TS_WORD2,
		TS_WORD3
	} ts_state_t;

	ts_state_t state;
	logic is_com_word;
	logic is_hdr_word;
	logic is_ts1_word;
	logic is_ts2_word;

	// four commas, all K
	assign is_com_word = link_in.word.datak == 4'hF && link_in.word.data == {4{SYM_COM}};

	// 00 00 ID ID, bits 19:16 hold link functions and are ignored
	assign is_hdr_word = link_in.word.datak == 4'h0 &&
		link_in.word.data[31:20] == 12'h000 &&
		link_in.word.data[15:8] == link_in.word.data[7:0] &&
		(link_in.word.data[7:0] == SYM_TS1_ID || link_in.word.data[7:0] == SYM_TS2_ID);

	assign is_ts1_word = link_in.word.datak == 4'h0 && link_in.word.data == {4{SYM_TS1_ID}};
	assign is_ts2_word = link_in.word.datak == 4'h0 && link_in.word.data == {4{SYM_TS2_ID}};

	//////////////////////////////////////////////////////////////////////
	// ordered set recogniser
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge local_clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= TS_IDLE;
			ltssm_train_ts1 <= 1'b0;
			ltssm_train_ts2 <= 1'b0;
		end else begin
			ltssm_train_ts1 <= 1'b0;
			ltssm_train_ts2 <= 1'b0;
			if (power_state != POWER_P0) begin
				// no training outside P0
				state <= TS_IDLE;
			end else if (link_in.active) begin
				case (state)
					TS_IDLE: begin
						if (is_com_word)
							state <= TS_WORD1;
					end
					TS_WORD1: begin
						state <= is_hdr_word ? TS_WORD2 : TS_IDLE;
					end
					TS_WORD2: begin
						state <= (is_ts1_word || is_ts2_word) ? TS_WORD3 : TS_IDLE;
					end
					TS_WORD3: begin
						// last word picks the set type
						ltssm_train_ts1 <= is_ts1_word;
						ltssm_train_ts2 <= is_ts2_word;
						state <= TS_IDLE;
					end
					default: begin
						state <= TS_IDLE;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rxdet_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module rxdet_ctrl
	import pipe_pkg::*;
#(
	parameter int RXDET_DELAY = DEFAULT_RXDET_DELAY,
	parameter int RXDET_TIMEOUT_BITS = DEFAULT_RXDET_TIMEOUT_BITS
) (
	input wire local_clk,
	input wire reset_n,
	input wire partner_detect,
	input wire power_state_t power_state,
	input wire [1:0] phy_status,
	input wire lane_status_t [1:0] rx_status,
	output logic partner_looking,
	output logic partner_detected,
	output logic phy_tx_detrx_lpbk
);

	// short answer in P0 or P1, looking then detected
	localparam int SHORT_LOOK = 2;
	localparam int SHORT_END = 9;
	localparam int RDC_BITS = $clog2(RXDET_DELAY + SHORT_END + 1);

	typedef enum logic [2:0] {
		RD_IDLE,
		RD_WAIT,
		RD_PROBE,
		RD_HOLD1,
		RD_HOLD2,
		RD_SHORT
	} rd_state_t;

	rd_state_t state;
	logic partner_detect_q;
	logic [RDC_BITS-1:0] rdc;
	logic [RXDET_TIMEOUT_BITS-1:0] timeout;
	logic request;
	logic lane_hit;

	assign request = partner_detect && !partner_detect_q;

	// lane 1 wins when both lanes report together
	assign lane_hit = phy_status[1] ? (rx_status[1] == RXSTAT_DETECTED) :
		(rx_status[0] == RXSTAT_DETECTED);

	always_ff @(posedge local_clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= RD_IDLE;
			partner_detect_q <= 1'b0;
			rdc <= '0;
			timeout <= '0;
			partner_looking <= 1'b0;
			partner_detected <= 1'b0;
			phy_tx_detrx_lpbk <= 1'b0;
		end else begin
			partner_detect_q <= partner_detect;
			rdc <= rdc + 1'b1;
			timeout <= timeout + 1'b1;
			partner_looking <= 1'b0;
			partner_detected <= 1'b0;
			phy_tx_detrx_lpbk <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (request) begin
						rdc <= '0;
						timeout <= '0;
						partner_looking <= 1'b1;
						// link already up, no need to probe
						if (power_state == POWER_P0 || power_state == POWER_P1)
							state <= RD_SHORT;
						else
							state <= RD_WAIT;
					end
				end
				RD_WAIT: begin
					partner_looking <= 1'b1;
					if (rdc == RDC_BITS'(RXDET_DELAY)) begin
						phy_tx_detrx_lpbk <= 1'b1;
						state <= RD_PROBE;
					end
				end
				RD_PROBE: begin
					partner_looking <= 1'b1;
					if (|phy_status) begin
						partner_detected <= lane_hit;
						state <= RD_HOLD1;
					end else if (timeout[RXDET_TIMEOUT_BITS-1]) begin
						// PHY never answered
						state <= RD_HOLD1;
					end else begin
						phy_tx_detrx_lpbk <= 1'b1;
					end
				end
				RD_HOLD1: begin
					partner_detected <= partner_detected;
					state <= RD_HOLD2;
				end
				RD_HOLD2: begin
					partner_detected <= partner_detected;
					state <= RD_IDLE;
				end
				RD_SHORT: begin
					if (rdc < RDC_BITS'(SHORT_LOOK))
						partner_looking <= 1'b1;
					else
						partner_detected <= 1'b1;
					if (rdc == RDC_BITS'(SHORT_END))
						state <= RD_IDLE;
				end
				default: begin
					state <= RD_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/phy_power_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module phy_power_ctrl
	import pipe_pkg::*;
(
	input wire local_clk,
	input wire reset_n,
	input wire [1:0] phy_status,
	input wire ltssm_power_go,
	input wire power_state_t ltssm_power_down,
	output power_state_t phy_power_down,
	output logic ltssm_power_ack,
	output logic ltssm_reset_n
);

	typedef enum logic [2:0] {
		PD_BOOT_ON,
		PD_BOOT_OFF,
		PD_IDLE,
		PD_CHANGE,
		PD_ACK
	} pd_state_t;

	pd_state_t state;
	logic power_go_q;
	logic request;

	assign request = ltssm_power_go && !power_go_q;

	always_ff @(posedge local_clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= PD_BOOT_ON;
			power_go_q <= 1'b0;
			phy_power_down <= POWER_P2;
			ltssm_power_ack <= 1'b0;
			ltssm_reset_n <= 1'b0;
		end else begin
			power_go_q <= ltssm_power_go;
			ltssm_power_ack <= 1'b0;
			case (state)
				// PHY pulses status once its power-on reset is done
				PD_BOOT_ON: begin
					if (|phy_status)
						state <= PD_BOOT_OFF;
				end
				PD_BOOT_OFF: begin
					if (phy_status == 2'b00) begin
						ltssm_reset_n <= 1'b1;
						state <= PD_IDLE;
					end
				end
				PD_IDLE: begin
					if (request) begin
						if (ltssm_power_down == phy_power_down) begin
							// nothing to change, acknowledge at once
							ltssm_power_ack <= 1'b1;
							state <= PD_ACK;
						end else begin
							phy_power_down <= ltssm_power_down;
							state <= PD_CHANGE;
						end
					end
				end
				PD_CHANGE: begin
					// PHY confirms the new state with a status pulse
					if (|phy_status) begin
						ltssm_power_ack <= 1'b1;
						state <= PD_ACK;
					end
				end
				PD_ACK: begin
					ltssm_power_ack <= 1'b1;
					state <= PD_IDLE;
				end
				default: begin
					state <= PD_BOOT_ON;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/usb3_pipe_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module usb3_pipe_rx
	import pipe_pkg::*;
#(
	parameter int RXDET_DELAY = DEFAULT_RXDET_DELAY,
	parameter int RXDET_TIMEOUT_BITS = DEFAULT_RXDET_TIMEOUT_BITS
) (
	input wire local_clk,
	input wire reset_n,

	// PHY side
	input wire pipe_word_t phy_rx,
	input wire [1:0] phy_rx_valid,
	input wire [1:0] phy_status,
	input wire lane_status_t [1:0] rx_status,
	output logic phy_tx_detrx_lpbk,
	output power_state_t phy_power_down,

	// LTSSM side
	input wire ltssm_power_go,
	input wire power_state_t ltssm_power_down,
	input wire partner_detect,
	output link_word_t link_in,
	output logic ltssm_train_ts1,
	output logic ltssm_train_ts2,
	output logic partner_looking,
	output logic partner_detected,
	output logic ltssm_power_ack,
	output logic ltssm_reset_n
);

	rx_word_align u_rx_word_align (
		.local_clk    (local_clk),
		.reset_n      (reset_n),
		.phy_rx       (phy_rx),
		.phy_rx_valid (phy_rx_valid),
		.link_in      (link_in)
	);

	// training sets only count in P0
	ts_detect u_ts_detect (
		.local_clk       (local_clk),
		.reset_n         (reset_n),
		.link_in         (link_in),
		.power_state     (phy_power_down),
		.ltssm_train_ts1 (ltssm_train_ts1),
		.ltssm_train_ts2 (ltssm_train_ts2)
	);

	rxdet_ctrl #(
		.RXDET_DELAY        (RXDET_DELAY),
		.RXDET_TIMEOUT_BITS (RXDET_TIMEOUT_BITS)
	) u_rxdet_ctrl (
		.local_clk         (local_clk),
		.reset_n           (reset_n),
		.partner_detect    (partner_detect),
		.power_state       (phy_power_down),
		.phy_status        (phy_status),
		.rx_status         (rx_status),
		.partner_looking   (partner_looking),
		.partner_detected  (partner_detected),
		.phy_tx_detrx_lpbk (phy_tx_detrx_lpbk)
	);

	phy_power_ctrl u_phy_power_ctrl (
		.local_clk        (local_clk),
		.reset_n          (reset_n),
		.phy_status       (phy_status),
		.ltssm_power_go   (ltssm_power_go),
		.ltssm_power_down (ltssm_power_down),
		.phy_power_down   (phy_power_down),
		.ltssm_power_ack  (ltssm_power_ack),
		.ltssm_reset_n    (ltssm_reset_n)
	);

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic local_clk,
	output logic reset_n
);

	initial begin
		local_clk = 1'b0;
		forever #(PERIOD_NS / 2) local_clk = ~local_clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge local_clk);
		@(negedge local_clk);
		reset_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sim/tb_usb3_pipe_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_usb3_pipe_rx
	import pipe_pkg::*;
;

	localparam int TIMEOUT_BITS = 12;
	localparam int DELAY = DEFAULT_RXDET_DELAY;
	// rough length of each group of tests in cycles
	localparam int TOTAL_CYCLES = 40 + 3 * 40 + 4 * 40 + 9 * 50 + 3 * 80 +
		(1 << TIMEOUT_BITS) + 1000;

	logic local_clk;
	logic reset_n;
	pipe_word_t phy_rx;
	logic [1:0] phy_rx_valid;
	logic [1:0] phy_status;
	lane_status_t [1:0] rx_status;
	logic ltssm_power_go;
	power_state_t ltssm_power_down;
	logic partner_detect;
	link_word_t link_in;
	logic ltssm_train_ts1;
	logic ltssm_train_ts2;
	logic partner_looking;
	logic partner_detected;
	logic phy_tx_detrx_lpbk;
	power_state_t phy_power_down;
	logic ltssm_power_ack;
	logic ltssm_reset_n;

	logic [31:0] lfsr_state = 32'h9db5_ee8c;
	// stimulus bytes in wire order as {k, byte}
	logic [8:0] stim_q[$];
	// bytes since the last cut that do not fill a word yet
	logic [8:0] pend_q[$];
	link_word_t expected_words[$];
	int ts1_pulses;
	int ts2_pulses;

	tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clock (
		.local_clk (local_clk),
		.reset_n   (reset_n)
	);

	usb3_pipe_rx #(
		.RXDET_DELAY        (DELAY),
		.RXDET_TIMEOUT_BITS (TIMEOUT_BITS)
	) dut (
		.local_clk         (local_clk),
		.reset_n           (reset_n),
		.phy_rx            (phy_rx),
		.phy_rx_valid      (phy_rx_valid),
		.phy_status        (phy_status),
		.rx_status         (rx_status),
		.phy_tx_detrx_lpbk (phy_tx_detrx_lpbk),
		.phy_power_down    (phy_power_down),
		.ltssm_power_go    (ltssm_power_go),
		.ltssm_power_down  (ltssm_power_down),
		.partner_detect    (partner_detect),
		.link_in           (link_in),
		.ltssm_train_ts1   (ltssm_train_ts1),
		.ltssm_train_ts2   (ltssm_train_ts2),
		.partner_looking   (partner_looking),
		.partner_detected  (partner_detected),
		.ltssm_power_ack   (ltssm_power_ack),
		.ltssm_reset_n     (ltssm_reset_n)
	);

	//////////////////////////////////////////////////////////////////////
	// failure reporting and compares
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input link_word_t got, input link_word_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_power(input string name, input power_state_t got,
		input power_state_t exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s got %s expected %s", $time, name,
				got.name(), exp.name()));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got,
				exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// random numbers and the reference model
	//////////////////////////////////////////////////////////////////////

	// one LFSR step per bit taken
	function automatic logic [31:0] next_random(input int nbits);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < nbits; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	function automatic logic is_framing(input logic [8:0] sym);
		return sym[8] && (sym[7:0] == SYM_COM || sym[7:0] == SYM_SKP ||
			sym[7:0] == SYM_SDP || sym[7:0] == SYM_SHP || sym[7:0] == SYM_END);
	endfunction

	// re-cut the byte stream with the first wire byte in bits 31:24
	function automatic void model_word(input logic [31:0] wdata, input logic [3:0] wk);
		logic [8:0] b[4];
		int run;
		int cut;
		link_word_t w;
		for (int j = 0; j < 4; j++)
			b[j] = {wk[3-j], wdata[31-8*j -: 8]};
		run = 0;
		while (run < 4 && is_framing(b[3-run]))
			run++;
		cut = -1;
		if (run == 4 && (b[3][7:0] == SYM_COM || b[3][7:0] == SYM_END))
			cut = 0;
		else if (run > 0)
			cut = 4 - ((run > 3) ? 3 : run);
		for (int j = 0; j < 4; j++) begin
			if (j == cut)
				pend_q.delete();
			pend_q.push_back(b[j]);
			if (pend_q.size() == 4) begin
				w.active = 1'b1;
				for (int m = 0; m < 4; m++) begin
					w.word.data[31-8*m -: 8] = pend_q[m][7:0];
					w.word.datak[3-m] = pend_q[m][8];
				end
				expected_words.push_back(w);
				pend_q.delete();
			end
		end
	endfunction

	// every active link_in word must be the next expected one
	always @(negedge local_clk) begin
		if (reset_n && link_in.active) begin
			if (expected_words.size() == 0)
				abort_run("link_in delivered a word that the stream does not contain");
			else
				check_word("link_in", link_in, expected_words.pop_front());
		end
	end

	always @(negedge local_clk) begin
		if (reset_n && ltssm_train_ts1)
			ts1_pulses++;
		if (reset_n && ltssm_train_ts2)
			ts2_pulses++;
	end

	initial begin
		repeat (TOTAL_CYCLES) @(posedge local_clk);
		abort_run("watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic push_data(input int count);
		for (int i = 0; i < count; i++)
			stim_q.push_back({1'b0, 8'(next_random(8))});
	endtask

	task automatic send_stream();
		pipe_word_t pw;
		logic [31:0] wdata;
		logic [3:0] wk;
		logic [8:0] item;
		logic [1:0] v;
		while (stim_q.size() % 4 != 0)
			push_data(1);
		while (stim_q.size() != 0) begin
			@(negedge local_clk);
			for (int j = 0; j < 4; j++) begin
				item = stim_q.pop_front();
				// PHY order puts the first byte low
				pw.data[8*j +: 8] = item[7:0];
				pw.datak[j] = item[8];
				wdata[31-8*j -: 8] = item[7:0];
				wk[3-j] = item[8];
			end
			model_word(wdata, wk);
			v = 2'(next_random(2));
			phy_rx = pw;
			phy_rx_valid = (v == 2'b00) ? 2'b11 : v;
		end
		@(negedge local_clk);
		phy_rx = '0;
		phy_rx_valid = 2'b00;
	endtask

	task automatic wait_drain();
		int i;
		i = 0;
		while (expected_words.size() != 0) begin
			if (i > 40)
				abort_run("expected link_in words never appeared");
			@(negedge local_clk);
			i++;
		end
	endtask

	task automatic power_request(input power_state_t target, input logic need_status);
		int acks;
		acks = 0;
		@(negedge local_clk);
		ltssm_power_down = target;
		ltssm_power_go = 1'b1;
		repeat (6) begin
			@(negedge local_clk);
			ltssm_power_go = 1'b0;
			acks += ltssm_power_ack;
		end
		check_power("phy_power_down", phy_power_down, target);
		if (need_status) begin
			check_count("ltssm_power_ack cycles before phy_status", acks, 0);
			phy_status = 2'b01;
			repeat (6) begin
				@(negedge local_clk);
				phy_status = 2'b00;
				acks += ltssm_power_ack;
			end
		end
		check_count("ltssm_power_ack cycles", acks, 2);
	endtask

	task automatic startup_case();
		int i;
		check_bit("link_in.active", link_in.active, 1'b0);
		check_bit("partner_looking", partner_looking, 1'b0);
		check_bit("phy_tx_detrx_lpbk", phy_tx_detrx_lpbk, 1'b0);
		repeat (5) @(negedge local_clk);
		check_bit("ltssm_reset_n", ltssm_reset_n, 1'b0);
		check_power("phy_power_down", phy_power_down, POWER_P2);
		phy_status = 2'b10;
		@(negedge local_clk);
		phy_status = 2'b00;
		check_bit("ltssm_reset_n", ltssm_reset_n, 1'b0);
		i = 0;
		while (!ltssm_reset_n) begin
			if (i > 10)
				abort_run("ltssm_reset_n never rose after the PHY status pulse");
			@(negedge local_clk);
			i++;
		end
	endtask

	task automatic align_case(input int offset);
		push_data(offset);
		for (int i = 0; i < 4; i++)
			stim_q.push_back({1'b1, SYM_COM});
		push_data(36 - offset);
		send_stream();
		wait_drain();
	endtask

	// one training set with filler before it and data after it
	task automatic ts_case(input int offset, input logic ts2, input logic corrupt,
		input logic expect_pulse);
		logic [7:0] id;
		id = ts2 ? SYM_TS2_ID : SYM_TS1_ID;
		ts1_pulses = 0;
		ts2_pulses = 0;
		push_data(offset);
		for (int i = 0; i < 4; i++)
			stim_q.push_back({1'b1, SYM_COM});
		stim_q.push_back(9'h000);
		stim_q.push_back({5'h00, 4'(next_random(4))});
		stim_q.push_back({1'b0, id});
		stim_q.push_back({1'b0, id});
		for (int i = 0; i < 8; i++)
			stim_q.push_back({1'b0, (corrupt && i == 2) ? 8'h00 : id});
		push_data(16 - offset);
		send_stream();
		wait_drain();
		repeat (3) @(negedge local_clk);
		check_count("ltssm_train_ts1 pulses", ts1_pulses, (expect_pulse && !ts2) ? 1 : 0);
		check_count("ltssm_train_ts2 pulses", ts2_pulses, (expect_pulse && ts2) ? 1 : 0);
	endtask

	task automatic probe_case(input int lane, input logic hit);
		int i;
		int detected;
		logic expect_hit;
		rx_status[lane] = hit ? RXSTAT_DETECTED : 3'b000;
		rx_status[1-lane] = hit ? 3'b000 : RXSTAT_DETECTED;
		expect_hit = rx_status[lane] == RXSTAT_DETECTED;
		detected = 0;
		@(negedge local_clk);
		partner_detect = 1'b1;
		@(negedge local_clk);
		check_bit("partner_looking", partner_looking, 1'b1);
		i = 0;
		while (!phy_tx_detrx_lpbk) begin
			if (i > DELAY + 10)
				abort_run("phy_tx_detrx_lpbk never rose after the detect request");
			@(negedge local_clk);
			i++;
		end
		phy_status[lane] = 1'b1;
		repeat (6) begin
			@(negedge local_clk);
			phy_status = 2'b00;
			detected += partner_detected;
		end
		check_count("partner_detected cycles", detected, expect_hit ? 3 : 0);
		check_bit("partner_looking", partner_looking, 1'b0);
		check_bit("phy_tx_detrx_lpbk", phy_tx_detrx_lpbk, 1'b0);
		partner_detect = 1'b0;
	endtask

	task automatic timeout_case();
		int i;
		int detected;
		detected = 0;
		@(negedge local_clk);
		partner_detect = 1'b1;
		i = 0;
		while (!phy_tx_detrx_lpbk) begin
			if (i > DELAY + 10)
				abort_run("phy_tx_detrx_lpbk never rose after the detect request");
			@(negedge local_clk);
			i++;
		end
		i = 0;
		while (partner_looking) begin
			if (i > (1 << TIMEOUT_BITS) + 20)
				abort_run("receiver detection did not time out");
			@(negedge local_clk);
			detected += partner_detected;
			i++;
		end
		check_count("partner_detected cycles", detected, 0);
		check_bit("phy_tx_detrx_lpbk", phy_tx_detrx_lpbk, 1'b0);
		partner_detect = 1'b0;
	endtask

	// link is up so the PHY is not probed
	task automatic short_case();
		int looking;
		int detected;
		int lpbk;
		int last_look;
		int first_det;
		looking = 0;
		detected = 0;
		lpbk = 0;
		last_look = -1;
		first_det = 100;
		@(negedge local_clk);
		partner_detect = 1'b1;
		for (int i = 0; i < 20; i++) begin
			@(negedge local_clk);
			looking += partner_looking;
			detected += partner_detected;
			lpbk += phy_tx_detrx_lpbk;
			if (partner_looking)
				last_look = i;
			if (partner_detected && first_det == 100)
				first_det = i;
		end
		check_bit("partner_looking about 3 cycles", looking >= 2 && looking <= 4, 1'b1);
		check_bit("partner_detected about 8 cycles", detected >= 6 && detected <= 10, 1'b1);
		check_bit("partner_detected after partner_looking", first_det > last_look, 1'b1);
		check_count("phy_tx_detrx_lpbk cycles", lpbk, 0);
		partner_detect = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		phy_rx = '0;
		phy_rx_valid = 2'b00;
		phy_status = 2'b00;
		rx_status = '0;
		ltssm_power_go = 1'b0;
		ltssm_power_down = POWER_P2;
		partner_detect = 1'b0;
		ts1_pulses = 0;
		ts2_pulses = 0;
		@(posedge reset_n);
		@(negedge local_clk);
		startup_case();
		power_request(POWER_P0, 1'b1);
		power_request(POWER_P0, 1'b0);
		for (int n = 0; n < 4; n++)
			align_case(n);
		for (int i = 0; i < 6; i++)
			ts_case(next_random(2), 1'(next_random(1)), 1'b0, 1'b1);
		ts_case(next_random(2), 1'b0, 1'b1, 1'b0);
		power_request(POWER_P2, 1'b1);
		ts_case(next_random(2), 1'b0, 1'b0, 1'b0);
		ts_case(next_random(2), 1'b1, 1'b0, 1'b0);
		probe_case(0, 1'b1);
		probe_case(1, 1'b0);
		timeout_case();
		power_request(POWER_P0, 1'b1);
		short_case();
		repeat (5) @(negedge local_clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/pipe_pkg.sv
hdl/rx_word_align.sv
hdl/ts_detect.sv
hdl/rxdet_ctrl.sv
hdl/phy_power_ctrl.sv
hdl/usb3_pipe_rx.sv
sim/tb_clock.sv
sim/tb_usb3_pipe_rx.sv

// ==== run.sh ====
#!/bin/sh
# build and run the receive adapter testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_usb3_pipe_rx -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
